/* rtl/nibble_decoder_pkg.sv */
package nibble_decoder_pkg;

  typedef logic [3:0]  nibble_t;
  typedef logic [19:0] addr_t;
  // wide enough for a 16 nibble immediate count
  typedef logic [4:0]  imm_len_t;

  // default immediate buffer depth
  localparam int MAX_IMM_NIBBLES_DEF = 16;

  // first nibbles with their own meaning
  localparam nibble_t OP_BLOCK_0X = 4'h0;
  localparam nibble_t OP_P_EQ_N   = 4'h2;
  localparam nibble_t OP_LOAD_IMM = 4'h3;
  localparam nibble_t OP_GOC      = 4'h4;
  localparam nibble_t OP_GONC     = 4'h5;
  localparam nibble_t OP_GOTO     = 4'h6;
  localparam nibble_t OP_GOSUB    = 4'h7;
  localparam nibble_t OP_BLOCK_CX = 4'hC;
  localparam nibble_t OP_BLOCK_DX = 4'hD;
  localparam nibble_t OP_BLOCK_FX = 4'hF;

  // operand lengths, zero means the next nibble gives it
  localparam imm_len_t IMM_LEN_FROM_NIBBLE = 5'd0;
  localparam imm_len_t IMM_LEN_REL2        = 5'd2;
  localparam imm_len_t IMM_LEN_REL3        = 5'd3;

  typedef enum logic [4:0] {
    ALU_OP_NONE     = 5'd0,
    ALU_OP_ZERO     = 5'd1,
    ALU_OP_COPY     = 5'd2,
    ALU_OP_EXCH     = 5'd3,
    ALU_OP_INC      = 5'd4,
    ALU_OP_DEC      = 5'd5,
    ALU_OP_ADD      = 5'd6,
    ALU_OP_2CMPL    = 5'd7,
    ALU_OP_JMP_REL2 = 5'd8,
    ALU_OP_JMP_REL3 = 5'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    GRP_0X,
    GRP_ARITH,
    GRP_IMM,
    GRP_JUMP,
    GRP_ERROR
  } group_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    ins_alu_op;
    logic    ins_rtn;
    logic    push;
    logic    pop;
    logic    set_xm;
    logic    set_carry;
    logic    carry_val;
    logic    test_carry;
    logic    en_intr;
    logic    ins_set_mode;
    logic    mode_dec;
    nibble_t imm_value;
  } dec_fields_t;

endpackage

// link between the sequencer and the immediate collector
interface imm_if
  import nibble_decoder_pkg::*;
#(
  parameter int MAX_IMM_NIBBLES = MAX_IMM_NIBBLES_DEF
);
  logic                         start;
  imm_len_t                     length;
  logic                         nibble_we;
  logic                         last;
  logic [4*MAX_IMM_NIBBLES-1:0] data;
  imm_len_t                     count;

  modport ctrl (output start, length, nibble_we, input last, data, count);
  modport coll (input start, length, nibble_we, output last, data, count);
endinterface

/* rtl/first_nibble_decoder.sv */
module first_nibble_decoder
  import nibble_decoder_pkg::*;
(
  input  nibble_t     i_nibble,
  output group_e      o_group,
  output imm_len_t    o_imm_len,
  output dec_fields_t o_fields
);

  always_comb begin
    o_group   = GRP_ERROR;
    o_imm_len = IMM_LEN_FROM_NIBBLE;
    o_fields  = '0;

    case (i_nibble)
      OP_BLOCK_0X: o_group = GRP_0X;
      OP_P_EQ_N, OP_BLOCK_CX, OP_BLOCK_DX, OP_BLOCK_FX: o_group = GRP_ARITH;
      OP_LOAD_IMM: begin
        // length follows as the first operand nibble
        o_group             = GRP_IMM;
        o_fields.alu_op     = ALU_OP_COPY;
        o_fields.ins_alu_op = 1'b1;
      end
      OP_GOC, OP_GONC: begin
        o_group             = GRP_JUMP;
        o_imm_len           = IMM_LEN_REL2;
        o_fields.alu_op     = ALU_OP_JMP_REL2;
        o_fields.ins_alu_op = 1'b1;
        o_fields.test_carry = 1'b1;
        o_fields.carry_val  = (i_nibble == OP_GOC);
      end
      OP_GOTO, OP_GOSUB: begin
        o_group             = GRP_JUMP;
        o_imm_len           = IMM_LEN_REL3;
        o_fields.alu_op     = ALU_OP_JMP_REL3;
        o_fields.ins_alu_op = 1'b1;
        o_fields.push       = (i_nibble == OP_GOSUB);
      end
      default: o_group = GRP_ERROR;
    endcase
  end

endmodule

/* rtl/block0_decoder.sv */
module block0_decoder
  import nibble_decoder_pkg::*;
(
  input  nibble_t     i_nibble,
  output dec_fields_t o_fields,
  output logic        o_err
);

  always_comb begin
    o_fields = '0;
    o_err    = 1'b0;

    case (i_nibble)
      // RTNSXM, RTN, RTNSC, RTNCC
      4'h0, 4'h1, 4'h2, 4'h3: begin
        o_fields.ins_rtn   = 1'b1;
        o_fields.pop       = 1'b1;
        o_fields.set_xm    = (i_nibble == 4'h0);
        o_fields.set_carry = i_nibble[1];
        o_fields.carry_val = i_nibble[1] && !i_nibble[0];
      end
      // RTI
      4'hF: begin
        o_fields.ins_rtn = 1'b1;
        o_fields.pop     = 1'b1;
        o_fields.en_intr = 1'b1;
      end
      // SETHEX / SETDEC
      4'h4, 4'h5: begin
        o_fields.ins_set_mode = 1'b1;
        o_fields.mode_dec     = i_nibble[0];
      end
      // RSTK=C pushes, C=RSTK pops
      4'h6, 4'h7: begin
        o_fields.ins_alu_op = 1'b1;
        o_fields.alu_op     = ALU_OP_COPY;
        o_fields.push       = !i_nibble[0];
        o_fields.pop        = i_nibble[0];
      end
      4'h8: begin
        o_fields.ins_alu_op = 1'b1;
        o_fields.alu_op     = ALU_OP_ZERO;
      end
      4'h9, 4'hA: begin
        o_fields.ins_alu_op = 1'b1;
        o_fields.alu_op     = ALU_OP_COPY;
      end
      4'hB: begin
        o_fields.ins_alu_op = 1'b1;
        o_fields.alu_op     = ALU_OP_EXCH;
      end
      // P=P+1 / P=P-1
      4'hC, 4'hD: begin
        o_fields.ins_alu_op = 1'b1;
        o_fields.alu_op     = i_nibble[0] ? ALU_OP_DEC : ALU_OP_INC;
      end
      default: o_err = 1'b1;
    endcase
  end

endmodule

/* rtl/reg_arith_decoder.sv */
module reg_arith_decoder
  import nibble_decoder_pkg::*;
(
  input  nibble_t     i_group_nibble,
  input  nibble_t     i_nibble,
  output dec_fields_t o_fields,
  output logic        o_err
);

  logic upper_quad;

  // x in C..F selects the second op of a group
  assign upper_quad = i_nibble[3] && i_nibble[2];

  always_comb begin
    o_fields            = '0;
    o_fields.ins_alu_op = 1'b1;
    o_err               = 1'b0;

    case (i_group_nibble)
      OP_P_EQ_N: begin
        o_fields.alu_op    = ALU_OP_COPY;
        o_fields.imm_value = i_nibble;
      end
      OP_BLOCK_CX: o_fields.alu_op = upper_quad ? ALU_OP_DEC : ALU_OP_ADD;
      OP_BLOCK_DX: o_fields.alu_op = upper_quad ? ALU_OP_EXCH : ALU_OP_COPY;
      OP_BLOCK_FX: begin
        // only r=-r is handled, 8..B
        if (i_nibble[3] && !i_nibble[2]) begin
          o_fields.alu_op = ALU_OP_2CMPL;
        end else begin
          o_err = 1'b1;
        end
      end
      default: o_err = 1'b1;
    endcase
  end

endmodule

/* rtl/immediate_collector.sv */
module immediate_collector
  import nibble_decoder_pkg::*;
#(
  parameter int MAX_IMM_NIBBLES = MAX_IMM_NIBBLES_DEF
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  nibble_t                      i_nibble,
  imm_if.coll                          imm,
  output logic [4*MAX_IMM_NIBBLES-1:0] o_imm_data,
  output imm_len_t                     o_imm_count
);

  localparam imm_len_t CAPACITY = imm_len_t'(MAX_IMM_NIBBLES);

  imm_len_t len_q;
  logic     need_len;
  imm_len_t count_next;
  logic     data_we;

  assign count_next = o_imm_count + 5'd1;
  // a length field nibble never counts as data
  assign data_we    = imm.nibble_we && !need_len;
  assign imm.last   = data_we && (count_next == len_q);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_imm_count <= '0;
      len_q       <= '0;
      need_len    <= 1'b0;
    end else if (imm.start) begin
      o_imm_count <= '0;
      len_q       <= imm.length;
      need_len    <= (imm.length == IMM_LEN_FROM_NIBBLE);
    end else if (imm.nibble_we) begin
      if (need_len) begin
        // 3n loads n+1 nibbles
        len_q    <= imm_len_t'(i_nibble) + 5'd1;
        need_len <= 1'b0;
      end else begin
        o_imm_count <= count_next;
      end
    end
  end

  // lowest nibble first, extra nibbles beyond capacity are dropped
  always_ff @(posedge i_clk) begin
    if (imm.start) begin
      o_imm_data <= '0;
    end else if (data_we && (o_imm_count < CAPACITY)) begin
      o_imm_data[o_imm_count*4 +: 4] <= i_nibble;
    end
  end

  assign imm.data  = o_imm_data;
  assign imm.count = o_imm_count;

endmodule

/* rtl/decode_sequencer.sv */
module decode_sequencer
  import nibble_decoder_pkg::*;
(
  input  logic        i_clk,
  input  logic        i_reset,
  input  logic        i_en_dec,
  input  logic        i_stalled,
  input  addr_t       i_pc,
  input  nibble_t     i_nibble,

  input  group_e      i_group,
  input  imm_len_t    i_imm_len,
  input  dec_fields_t i_first_fields,
  input  dec_fields_t i_blk0_fields,
  input  logic        i_blk0_err,
  input  dec_fields_t i_arith_fields,
  input  logic        i_arith_err,

  output nibble_t     o_first_nibble_held,
  output logic        o_ins_decoded,
  output logic        o_dec_error,
  output addr_t       o_ins_addr,
  output dec_fields_t o_fields,

  imm_if.ctrl         imm
);

  // the state also remembers the group of the first nibble
  typedef enum logic [1:0] {
    ST_FIRST,
    ST_SECOND_0X,
    ST_SECOND_ARITH,
    ST_OPERAND
  } state_e;

  state_e state;
  logic   accept;
  logic   first_accept;

  // one nibble per enabled, unstalled cycle
  assign accept       = i_en_dec && !i_stalled;
  assign first_accept = accept && (state == ST_FIRST);

  assign imm.start     = first_accept && ((i_group == GRP_IMM) || (i_group == GRP_JUMP));
  assign imm.length    = i_imm_len;
  assign imm.nibble_we = accept && (state == ST_OPERAND);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state         <= ST_FIRST;
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;
      o_fields      <= '0;
    end else begin
      // pulses last one cycle at most
      o_ins_decoded <= 1'b0;
      o_dec_error   <= 1'b0;

      if (accept) begin
        case (state)
          ST_FIRST: begin
            // jumps and loads come preset, others start cleared
            o_fields <= i_first_fields;
            case (i_group)
              GRP_0X:    state <= ST_SECOND_0X;
              GRP_ARITH: state <= ST_SECOND_ARITH;
              GRP_IMM,
              GRP_JUMP:  state <= ST_OPERAND;
              default:   o_dec_error <= 1'b1;
            endcase
          end

          ST_SECOND_0X: begin
            state <= ST_FIRST;
            if (i_blk0_err) begin
              o_dec_error <= 1'b1;
            end else begin
              o_fields      <= i_blk0_fields;
              o_ins_decoded <= 1'b1;
            end
          end

          ST_SECOND_ARITH: begin
            state <= ST_FIRST;
            if (i_arith_err) begin
              o_dec_error <= 1'b1;
            end else begin
              o_fields      <= i_arith_fields;
              o_ins_decoded <= 1'b1;
            end
          end

          ST_OPERAND: begin
            // keep the latest operand nibble visible
            o_fields.imm_value <= i_nibble;
            if (imm.last) begin
              state         <= ST_FIRST;
              o_ins_decoded <= 1'b1;
            end
          end

          default: state <= ST_FIRST;
        endcase
      end
    end
  end

  // instruction address and group nibble
  always_ff @(posedge i_clk) begin
    if (first_accept) begin
      o_ins_addr          <= i_pc;
      o_first_nibble_held <= i_nibble;
    end
  end

endmodule

/* rtl/nibble_decoder_top.sv */
module nibble_decoder_top
  import nibble_decoder_pkg::*;
#(
  parameter int MAX_IMM_NIBBLES = MAX_IMM_NIBBLES_DEF
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_en_dec,
  input  logic                         i_stalled,
  input  addr_t                        i_pc,
  input  nibble_t                      i_nibble,

  output logic                         o_ins_decoded,
  output logic                         o_dec_error,
  output addr_t                        o_ins_addr,
  output alu_op_e                      o_alu_op,
  output logic                         o_ins_alu_op,
  output logic                         o_ins_rtn,
  output logic                         o_push,
  output logic                         o_pop,
  output logic                         o_set_xm,
  output logic                         o_set_carry,
  output logic                         o_carry_val,
  output logic                         o_test_carry,
  output logic                         o_en_intr,
  output logic                         o_ins_set_mode,
  output logic                         o_mode_dec,
  output nibble_t                      o_imm_value,
  output logic [4*MAX_IMM_NIBBLES-1:0] o_imm_data,
  output imm_len_t                     o_imm_count
);

  group_e      group;
  imm_len_t    imm_len;
  dec_fields_t first_fields;
  dec_fields_t blk0_fields;
  logic        blk0_err;
  dec_fields_t arith_fields;
  logic        arith_err;
  nibble_t     first_nibble_held;
  dec_fields_t fields;

  imm_if #(.MAX_IMM_NIBBLES(MAX_IMM_NIBBLES)) imm ();

  decode_sequencer u_seq (
    .i_clk               (i_clk),
    .i_reset             (i_reset),
    .i_en_dec            (i_en_dec),
    .i_stalled           (i_stalled),
    .i_pc                (i_pc),
    .i_nibble            (i_nibble),
    .i_group             (group),
    .i_imm_len           (imm_len),
    .i_first_fields      (first_fields),
    .i_blk0_fields       (blk0_fields),
    .i_blk0_err          (blk0_err),
    .i_arith_fields      (arith_fields),
    .i_arith_err         (arith_err),
    .o_first_nibble_held (first_nibble_held),
    .o_ins_decoded       (o_ins_decoded),
    .o_dec_error         (o_dec_error),
    .o_ins_addr          (o_ins_addr),
    .o_fields            (fields),
    .imm                 (imm.ctrl)
  );

  first_nibble_decoder u_first (
    .i_nibble  (i_nibble),
    .o_group   (group),
    .o_imm_len (imm_len),
    .o_fields  (first_fields)
  );

  block0_decoder u_blk0 (
    .i_nibble (i_nibble),
    .o_fields (blk0_fields),
    .o_err    (blk0_err)
  );

  // the group nibble comes back from the sequencer
  reg_arith_decoder u_arith (
    .i_group_nibble (first_nibble_held),
    .i_nibble       (i_nibble),
    .o_fields       (arith_fields),
    .o_err          (arith_err)
  );

  immediate_collector #(.MAX_IMM_NIBBLES(MAX_IMM_NIBBLES)) u_imm (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_nibble    (i_nibble),
    .imm         (imm.coll),
    .o_imm_data  (o_imm_data),
    .o_imm_count (o_imm_count)
  );

  assign o_alu_op       = fields.alu_op;
  assign o_ins_alu_op   = fields.ins_alu_op;
  assign o_ins_rtn      = fields.ins_rtn;
  assign o_push         = fields.push;
  assign o_pop          = fields.pop;
  assign o_set_xm       = fields.set_xm;
  assign o_set_carry    = fields.set_carry;
  assign o_carry_val    = fields.carry_val;
  assign o_test_carry   = fields.test_carry;
  assign o_en_intr      = fields.en_intr;
  assign o_ins_set_mode = fields.ins_set_mode;
  assign o_mode_dec     = fields.mode_dec;
  assign o_imm_value    = fields.imm_value;

endmodule

/* test/decode_sequencer_checker.sv */
module decode_sequencer_checker (
  input logic i_clk,
  input logic i_reset,
  input logic i_en_dec,
  input logic i_stalled,
  input logic o_ins_decoded,
  input logic o_dec_error
);

  a_not_both: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_ins_decoded && o_dec_error))
    else $error("decoded and error pulses high together");

  a_decoded_single: assert property (@(posedge i_clk) disable iff (i_reset)
    o_ins_decoded |=> !o_ins_decoded)
    else $error("decoded pulse longer than one cycle");

  a_error_single: assert property (@(posedge i_clk) disable iff (i_reset)
    o_dec_error |=> !o_dec_error)
    else $error("error pulse longer than one cycle");

  // a pulse is set only on an accepting edge
  a_pulse_after_accept: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_ins_decoded || o_dec_error) |-> $past(i_en_dec && !i_stalled))
    else $error("pulse without an accepted nibble");

  a_quiet_after_reset: assert property (@(posedge i_clk)
    i_reset |=> !(o_ins_decoded || o_dec_error))
    else $error("pulse in the cycle after reset");

endmodule

bind decode_sequencer decode_sequencer_checker u_checker (.*);

/* test/nibble_decoder_tb.sv */
module nibble_decoder_tb
  import nibble_decoder_pkg::*;
();

  localparam int          IMM_N          = MAX_IMM_NIBBLES_DEF;
  localparam int unsigned SEED           = 32'h7e0956a8;
  // about 500 cycles for the plain pass, the stalled pass at most about 1200
  localparam int          TIMEOUT_CYCLES = 5000;

  typedef logic [4*IMM_N-1:0] imm_data_t;

  logic      i_clk;
  logic      i_reset;
  logic      i_en_dec;
  logic      i_stalled;
  addr_t     i_pc;
  nibble_t   i_nibble;
  logic      o_ins_decoded;
  logic      o_dec_error;
  addr_t     o_ins_addr;
  alu_op_e   o_alu_op;
  logic      o_ins_alu_op;
  logic      o_ins_rtn;
  logic      o_push;
  logic      o_pop;
  logic      o_set_xm;
  logic      o_set_carry;
  logic      o_carry_val;
  logic      o_test_carry;
  logic      o_en_intr;
  logic      o_ins_set_mode;
  logic      o_mode_dec;
  nibble_t   o_imm_value;
  imm_data_t o_imm_data;
  imm_len_t  o_imm_count;

  int          value_errs  = 0;
  int          other_errs  = 0;
  int          cycle_count = 0;
  logic        stall_mode  = 1'b0;
  addr_t       pc          = 20'h01000;

  nibble_decoder_top #(.MAX_IMM_NIBBLES(IMM_N)) u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_fields(input dec_fields_t exp);
    dec_fields_t act;
    act = {o_alu_op, o_ins_alu_op, o_ins_rtn, o_push, o_pop, o_set_xm, o_set_carry,
           o_carry_val, o_test_carry, o_en_intr, o_ins_set_mode, o_mode_dec, o_imm_value};
    if (act !== exp) begin
      value_errs++;
      $display("ERR o_alu_op..o_imm_value exp 0x%h got 0x%h (alu_op exp 0x%h got 0x%h)",
               exp, act, exp.alu_op, act.alu_op);
    end
  endtask

  task automatic check_addr(input addr_t exp);
    if (o_ins_addr !== exp) begin
      value_errs++;
      $display("ERR o_ins_addr exp 0x%h got 0x%h", exp, o_ins_addr);
    end
  endtask

  task automatic check_imm(input imm_data_t exp_data, input imm_len_t exp_count);
    if (o_imm_data !== exp_data) begin
      value_errs++;
      $display("ERR o_imm_data exp 0x%h got 0x%h", exp_data, o_imm_data);
    end
    if (o_imm_count !== exp_count) begin
      value_errs++;
      $display("ERR o_imm_count exp 0x%h got 0x%h", exp_count, o_imm_count);
    end
  endtask

  // expected result of a two nibble instruction, taken from the opcode tables
  function automatic void expect_two_nibble(input nibble_t first, input nibble_t second,
                                            output dec_fields_t f, output logic err);
    f   = '0;
    err = 1'b0;
    if (first == 4'h0) begin
      case (second)
        4'h0: {f.ins_rtn, f.pop, f.set_xm} = 3'b111;
        4'h1: {f.ins_rtn, f.pop} = 2'b11;
        4'h2: {f.ins_rtn, f.pop, f.set_carry, f.carry_val} = 4'b1111;
        4'h3: {f.ins_rtn, f.pop, f.set_carry} = 3'b111;
        4'hF: {f.ins_rtn, f.pop, f.en_intr} = 3'b111;
        4'h4: f.ins_set_mode = 1'b1;
        4'h5: {f.ins_set_mode, f.mode_dec} = 2'b11;
        4'h6: {f.alu_op, f.push} = {ALU_OP_COPY, 1'b1};
        4'h7: {f.alu_op, f.pop} = {ALU_OP_COPY, 1'b1};
        4'h8: f.alu_op = ALU_OP_ZERO;
        4'h9, 4'hA: f.alu_op = ALU_OP_COPY;
        4'hB: f.alu_op = ALU_OP_EXCH;
        4'hC: f.alu_op = ALU_OP_INC;
        4'hD: f.alu_op = ALU_OP_DEC;
        default: err = 1'b1;
      endcase
      f.ins_alu_op = (f.alu_op != ALU_OP_NONE);
    end else begin
      f.ins_alu_op = 1'b1;
      case (first)
        4'h2: {f.alu_op, f.imm_value} = {ALU_OP_COPY, second};
        4'hC: f.alu_op = (second >= 4'hC) ? ALU_OP_DEC : ALU_OP_ADD;
        4'hD: f.alu_op = (second >= 4'hC) ? ALU_OP_EXCH : ALU_OP_COPY;
        default: begin
          if (second >= 4'h8 && second <= 4'hB) begin
            f.alu_op = ALU_OP_2CMPL;
          end else begin
            err = 1'b1;
          end
        end
      endcase
    end
  endfunction

  task automatic expect_quiet();
    if (o_ins_decoded || o_dec_error) begin
      other_errs++;
      $display("a decoded or error pulse appeared before the instruction was complete");
    end
  endtask

  // optional stall or enable drop cycles, then one accepted nibble
  task automatic send_nibble(input nibble_t nib);
    int stalls;
    stalls = stall_mode ? int'($urandom % 3) : 0;
    repeat (stalls) begin
      @(negedge i_clk);
      expect_quiet();
      if ($urandom % 2 == 0) begin
        i_en_dec  = 1'b0;
        i_stalled = 1'b0;
      end else begin
        i_en_dec  = 1'b1;
        i_stalled = 1'b1;
      end
      i_nibble = nibble_t'($urandom);
      i_pc     = addr_t'($urandom);
    end
    @(negedge i_clk);
    expect_quiet();
    i_en_dec  = 1'b1;
    i_stalled = 1'b0;
    i_nibble  = nib;
    i_pc      = pc;
    pc        = pc + 20'd1;
  endtask

  task automatic await_result(input logic want_err, output logic ok);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    ok     = 1'b0;
    while (!seen && waited < 4) begin
      @(negedge i_clk);
      i_en_dec  = 1'b0;
      i_stalled = 1'b0;
      seen      = o_ins_decoded || o_dec_error;
      waited++;
    end
    if (!seen) begin
      other_errs++;
      $display("no decoded or error pulse followed the last nibble");
    end else if (o_dec_error !== want_err || o_ins_decoded !== !want_err) begin
      other_errs++;
      $display("wrong pulse, expected %s", want_err ? "an error pulse" : "a decoded pulse");
    end else if (waited != 1) begin
      other_errs++;
      $display("pulse came %0d cycles after the last nibble instead of one", waited);
    end else begin
      ok = 1'b1;
    end
  endtask

  task automatic run_two_nibble(input nibble_t first, input nibble_t second);
    dec_fields_t exp;
    logic        exp_err;
    logic        ok;
    addr_t       start_pc;
    expect_two_nibble(first, second, exp, exp_err);
    start_pc = pc;
    send_nibble(first);
    send_nibble(second);
    await_result(exp_err, ok);
    if (ok && !exp_err) begin
      check_fields(exp);
      check_addr(start_pc);
    end
  endtask

  // loads and jumps, n_data random operand nibbles
  task automatic run_operand_ins(input nibble_t first, input int n_data);
    dec_fields_t exp;
    imm_data_t   exp_data;
    nibble_t     nib;
    logic        ok;
    addr_t       start_pc;
    exp            = '0;
    exp.ins_alu_op = 1'b1;
    case (first)
      4'h3: exp.alu_op = ALU_OP_COPY;
      4'h4: {exp.alu_op, exp.test_carry, exp.carry_val} = {ALU_OP_JMP_REL2, 2'b11};
      4'h5: {exp.alu_op, exp.test_carry} = {ALU_OP_JMP_REL2, 1'b1};
      4'h6: exp.alu_op = ALU_OP_JMP_REL3;
      default: {exp.alu_op, exp.push} = {ALU_OP_JMP_REL3, 1'b1};
    endcase
    exp_data = '0;
    nib      = '0;
    start_pc = pc;
    send_nibble(first);
    if (first == 4'h3) begin
      send_nibble(nibble_t'(n_data - 1));
    end
    for (int i = 0; i < n_data; i++) begin
      nib                = nibble_t'($urandom);
      exp_data[i*4 +: 4] = nib;
      send_nibble(nib);
    end
    exp.imm_value = nib;
    await_result(1'b0, ok);
    if (ok) begin
      check_fields(exp);
      check_addr(start_pc);
      check_imm(exp_data, imm_len_t'(n_data));
    end
  endtask

  task automatic block0_sweep();
    for (int n = 0; n < 16; n++) begin
      run_two_nibble(4'h0, nibble_t'(n));
    end
  endtask

  task automatic reg_arith_sweep();
    nibble_t groups[4];
    groups = '{4'h2, 4'hC, 4'hD, 4'hF};
    foreach (groups[g]) begin
      for (int x = 0; x < 16; x++) begin
        run_two_nibble(groups[g], nibble_t'(x));
      end
    end
  endtask

  task automatic load_imm_sweep();
    for (int n = 0; n < 16; n++) begin
      run_operand_ins(4'h3, n + 1);
    end
  endtask

  task automatic jump_cases();
    for (int op = 4; op <= 7; op++) begin
      repeat (2) run_operand_ins(nibble_t'(op), (op < 6) ? 2 : 3);
    end
  endtask

  // unhandled first nibbles, each followed by a plain RTN
  task automatic bad_first_nibbles();
    nibble_t bad[6];
    logic    ok;
    bad = '{4'h1, 4'h8, 4'h9, 4'hA, 4'hB, 4'hE};
    foreach (bad[i]) begin
      send_nibble(bad[i]);
      await_result(1'b1, ok);
      run_two_nibble(4'h0, 4'h1);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    i_reset   = 1'b1;
    i_en_dec  = 1'b0;
    i_stalled = 1'b0;
    i_pc      = '0;
    i_nibble  = '0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset = 1'b0;
    expect_quiet();
    check_fields('0);

    block0_sweep();
    reg_arith_sweep();
    load_imm_sweep();
    jump_cases();
    bad_first_nibbles();

    // same instructions again with stalls and enable drops
    stall_mode = 1'b1;
    block0_sweep();
    reg_arith_sweep();
    load_imm_sweep();
    jump_cases();

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/nibble_decoder_pkg.sv
rtl/first_nibble_decoder.sv
rtl/block0_decoder.sv
rtl/reg_arith_decoder.sv
rtl/immediate_collector.sv
rtl/decode_sequencer.sv
rtl/nibble_decoder_top.sv
test/decode_sequencer_checker.sv
test/nibble_decoder_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the nibble decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module nibble_decoder_tb --Mdir obj_dir -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -qx "Test completed successfully" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }
